//--- uopPkg.sv
// Micro-op sequencer definitions
`default_nettype none

package uopPkg;

	typedef logic [31:0] instrT;      // Instruction word
	typedef logic [3:0]  regIdxT;     // Register index
	typedef logic [15:0] regListT;    // LDM/STM list, bit i is register i
	typedef logic [3:0]  flagsT;      // NZCV with N on top
	typedef logic [3:0]  condT;       // Condition field
	typedef logic [3:0]  rzSelT;      // Rz routing to the register file

	// Rz routing bits, high to low
	// 3 steers the first read port when an RSR run starts
	// 2 sends the write to Rz
	// 1 sends the second read to Rz
	// 0 sends the first read to Rz

	typedef enum logic [2:0] {
		ready,            // Pass through or first micro-op of a run
		rsrSecond,        // Original op reading Rz
		blSecond,         // Plain branch after the LR move
		blockXfer,        // One register per cycle
		blockWriteback    // Base register update
	} seqStateT;

	typedef enum logic [2:0] {
		plain,
		rsr,              // Register-shifted-register data processing
		branchLink,
		loadMultiple,
		storeMultiple
	} seqKindT;

	localparam regIdxT scratchReg = 4'd15;   // Index inside the Rz space
	localparam regIdxT linkReg    = 4'd14;
	localparam regIdxT pcReg      = 4'd15;

	localparam condT condAlways = 4'b1110;

	localparam logic [3:0] opcodeMov = 4'b1101;
	localparam logic [3:0] opcodeAdd = 4'b0100;
	localparam logic [3:0] opcodeSub = 4'b0010;

	localparam int wordBytes = 4;   // Address step per register

	// Instruction field positions
	localparam int condHi    = 31;
	localparam int condLo    = 28;
	localparam int pBit      = 24;   // Pre index
	localparam int uBit      = 23;   // Up
	localparam int wBit      = 21;   // Base writeback
	localparam int lBit      = 20;   // Load
	localparam int rnHi      = 19;
	localparam int rnLo      = 16;
	localparam int rdHi      = 15;
	localparam int rdLo      = 12;
	localparam int rsHi      = 11;
	localparam int rsLo      = 8;
	localparam int regListHi = 15;
	localparam int regListLo = 0;

endpackage

`default_nettype wire

//--- condCheck.sv
// ARM condition evaluation
`timescale 1ns/1ps
`default_nettype none

module condCheck (
	input  uopPkg::condT  cond,
	input  uopPkg::flagsT flags,
	output logic          condPass
);

	logic flagN;
	logic flagZ;
	logic flagC;
	logic flagV;

	assign {flagN, flagZ, flagC, flagV} = flags;

	always_comb begin
		case (cond)
			4'b0000: condPass = flagZ;                              // EQ
			4'b0001: condPass = !flagZ;                             // NE
			4'b0010: condPass = flagC;                              // CS
			4'b0011: condPass = !flagC;                             // CC
			4'b0100: condPass = flagN;                              // MI
			4'b0101: condPass = !flagN;                             // PL
			4'b0110: condPass = flagV;                              // VS
			4'b0111: condPass = !flagV;                             // VC
			4'b1000: condPass = flagC && !flagZ;                    // HI
			4'b1001: condPass = !flagC || flagZ;                    // LS
			4'b1010: condPass = (flagN == flagV);                   // GE
			4'b1011: condPass = (flagN != flagV);                   // LT
			4'b1100: condPass = !flagZ && (flagN == flagV);         // GT
			4'b1101: condPass = flagZ || (flagN != flagV);          // LE
			uopPkg::condAlways: condPass = 1'b1;                    // AL
			default: condPass = 1'b0;                               // NV never runs
		endcase
	end

endmodule

`default_nettype wire

//--- uopDecoder.sv
// Instruction class decoder
`timescale 1ns/1ps
`default_nettype none

module uopDecoder (
	input  uopPkg::instrT   instr,
	output uopPkg::seqKindT kind
);

	logic isBx;      // BX or BLX register form
	logic isRsr;
	logic isBl;
	logic isBlock;   // LDM or STM

	// BX/BLX shares the RSR bit pattern, so it is picked out first
	assign isBx = (instr[27:20] == 8'b0001_0010)
		&& (instr[uopPkg::rnHi:uopPkg::rnLo] == 4'hf)    // SBO
		&& (instr[uopPkg::rdHi:uopPkg::rdLo] == 4'hf)    // SBO
		&& (instr[uopPkg::rsHi:uopPkg::rsLo] == 4'hf)    // SBO
		&& (instr[7:6] == 2'b00);

	assign isRsr = (instr[27:25] == 3'b000)   // Data processing, register operand
		&& !instr[7]
		&& instr[4]                           // Shift amount from Rs
		&& !isBx;

	assign isBl = (instr[27:24] == 4'b1011);    // Branch with L set

	assign isBlock = (instr[27:25] == 3'b100);  // Block data transfer

	always_comb begin
		if (isRsr) begin
			kind = uopPkg::rsr;
		end else if (isBl) begin
			kind = uopPkg::branchLink;
		end else if (isBlock) begin
			if (instr[uopPkg::lBit]) begin
				kind = uopPkg::loadMultiple;
			end else begin
				kind = uopPkg::storeMultiple;
			end
		end else begin
			kind = uopPkg::plain;   // Passes straight through
		end
	end

endmodule

`default_nettype wire

//--- blockTransferCounter.sv
// LDM/STM register list tracker
`timescale 1ns/1ps
`default_nettype none

module blockTransferCounter (
	input  logic           clk,
	input  logic           reset,
	input  logic           stallUop,
	input  uopPkg::instrT  instr,
	input  logic           inReady,
	output uopPkg::regIdxT nextReg,
	output logic [4:0]     remaining,
	output logic [11:0]    startOffset,
	output logic           addUp,
	output logic           lastReg,
	output logic           noneLeft
);

	uopPkg::regListT listNow;      // Registers still to move
	uopPkg::regListT curList;      // List this cycle works from
	uopPkg::regListT listNext;
	logic [4:0]      totalRegs;    // N from the instruction
	logic [4:0]      offsetWords;  // Start offset in words
	logic            writeBack;

	assign curList   = inReady ? instr[uopPkg::regListHi:uopPkg::regListLo] : listNow;
	assign listNext  = curList & (curList - 16'd1);   // Drop lowest set bit
	assign remaining = 5'($countones(curList));
	assign totalRegs = 5'($countones(instr[uopPkg::regListHi:uopPkg::regListLo]));
	assign writeBack = instr[uopPkg::wBit];

	assign lastReg  = (remaining == 5'd1);   // This cycle moves the final register
	// Nothing follows the current micro-op
	// An empty list gets the no-op, a last register without W ends the run
	assign noneLeft = (remaining == 5'd0) || (lastReg && !writeBack);

	always_ff @(posedge clk) begin
		if (reset) begin
			listNow <= '0;
		end else if (!stallUop) begin
			listNow <= listNext;   // Held while the pipeline holds us
		end
	end

	// Lowest set bit goes first
	always_comb begin
		nextReg = '0;
		for (int i = 15; i >= 0; i--) begin
			if (curList[i]) begin
				nextReg = 4'(i);
			end
		end
	end

	always_comb begin
		case ({instr[uopPkg::pBit], instr[uopPkg::uBit]})
			2'b00: begin   // DA
				offsetWords = totalRegs - 5'd1;
				addUp       = 1'b0;
			end
			2'b01: begin   // IA
				offsetWords = 5'd0;
				addUp       = 1'b1;
			end
			2'b10: begin   // DB
				offsetWords = totalRegs;
				addUp       = 1'b0;
			end
			default: begin   // IB
				offsetWords = 5'd1;
				addUp       = 1'b1;
			end
		endcase
	end

	assign startOffset = 12'(offsetWords) * 12'(uopPkg::wordBytes);

endmodule

`default_nettype wire

//--- uopController.sv
// Sequencer state and control levels
`timescale 1ns/1ps
`default_nettype none

module uopController (
	input  logic             clk,
	input  logic             reset,
	input  logic             stallUop,
	input  uopPkg::seqKindT  kind,
	input  logic             condPass,
	input  logic             lastReg,
	input  logic             noneLeft,
	output uopPkg::seqStateT state,
	output logic             inReady,
	output logic             instrMux,
	output logic             noFlagUpdate,
	output logic             uOpStall,
	output logic             ldmStmForward,
	output logic             prevRsrState,
	output uopPkg::rzSelT    regFileRz
);

	uopPkg::seqStateT nextState;
	logic             blockKind;    // LDM or STM in decode
	logic             xferIssued;   // blockXfer cycle that moves a register

	assign blockKind  = (kind == uopPkg::loadMultiple) || (kind == uopPkg::storeMultiple);
	assign xferIssued = (state == uopPkg::blockXfer) && condPass && (lastReg || !noneLeft);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uopPkg::ready;
		end else if (!stallUop) begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			uopPkg::ready: begin
				case (kind)
					uopPkg::rsr:        nextState = uopPkg::rsrSecond;
					uopPkg::branchLink: nextState = uopPkg::blSecond;
					uopPkg::loadMultiple, uopPkg::storeMultiple: begin
						if (lastReg && noneLeft) begin
							nextState = uopPkg::ready;            // Single register, done
						end else if (lastReg && condPass) begin
							nextState = uopPkg::blockWriteback;   // One register then W
						end else begin
							nextState = uopPkg::blockXfer;
						end
					end
					default: nextState = uopPkg::ready;
				endcase
			end
			uopPkg::blockXfer: begin
				if (!condPass || (noneLeft && !lastReg)) begin
					nextState = uopPkg::ready;            // No-op ends the run
				end else if (lastReg && !noneLeft) begin
					nextState = uopPkg::blockWriteback;
				end else if (lastReg) begin
					nextState = uopPkg::ready;
				end else begin
					nextState = uopPkg::blockXfer;
				end
			end
			default: nextState = uopPkg::ready;   // Second cycles and writeback end here
		endcase
	end

	assign inReady       = (state == uopPkg::ready);
	assign instrMux      = !inReady || (kind != uopPkg::plain);
	assign uOpStall      = (nextState != uopPkg::ready);   // Fetch waits while more follows
	assign prevRsrState  = (state == uopPkg::rsrSecond);
	assign ldmStmForward = xferIssued;
	assign noFlagUpdate  = (inReady && ((kind == uopPkg::rsr) || blockKind))
		|| (state == uopPkg::blockXfer)
		|| (state == uopPkg::blockWriteback);

	always_comb begin
		if (inReady && (kind == uopPkg::rsr)) begin
			regFileRz = 4'b1100;   // Write Rz, RA1 mux
		end else if (state == uopPkg::rsrSecond) begin
			regFileRz = 4'b0010;   // Shifted operand from Rz
		end else if ((state == uopPkg::blockXfer) && (kind == uopPkg::loadMultiple)) begin
			regFileRz = 4'b0001;   // Base address from Rz
		end else begin
			regFileRz = 4'b0000;
		end
	end

endmodule

`default_nettype wire

//--- uopEncoder.sv
// Micro-op instruction builder
`timescale 1ns/1ps
`default_nettype none

module uopEncoder (
	input  uopPkg::seqStateT state,
	input  uopPkg::seqKindT  kind,
	input  uopPkg::instrT    instr,
	input  logic             condPass,
	input  uopPkg::regIdxT   nextReg,
	input  logic [4:0]       remaining,
	input  logic [11:0]      startOffset,
	input  logic             addUp,
	output uopPkg::instrT    uOpInstr
);

	uopPkg::condT   cond;
	uopPkg::regIdxT rn;
	logic           loadBit;
	logic [4:0]     totalRegs;     // N for the writeback immediate
	uopPkg::instrT  noOp;
	uopPkg::instrT  rsrMove;
	uopPkg::instrT  rsrOp;
	uopPkg::instrT  linkMove;
	uopPkg::instrT  blockFirst;
	uopPkg::instrT  blockNext;
	uopPkg::instrT  writeback;

	assign cond      = instr[uopPkg::condHi:uopPkg::condLo];
	assign rn        = instr[uopPkg::rnHi:uopPkg::rnLo];
	assign loadBit   = instr[uopPkg::lBit];
	assign totalRegs = 5'($countones(instr[uopPkg::regListHi:uopPkg::regListLo]));

	// ADD R0, R0, #0 that carries the original condition
	assign noOp = {cond, 3'b001, uopPkg::opcodeAdd, 1'b0, 20'b0};

	assign rsrMove = {cond, 3'b000, uopPkg::opcodeMov, 1'b0,   // MOV, flags kept
		4'b0000, uopPkg::scratchReg,                           // Rz gets the shifted value
		instr[11:0]};

	assign rsrOp = {instr[31:12], 8'b0, uopPkg::scratchReg};  // Unshifted Rz operand

	assign linkMove = {cond, 3'b000, uopPkg::opcodeMov, 1'b0,
		4'b0000, uopPkg::linkReg,
		8'b0, uopPkg::pcReg};   // LR = PC

	assign blockFirst = {cond, 3'b010,   // Immediate single transfer
		1'b1,                            // P
		addUp,                           // U
		1'b0,                            // Word access
		1'b0,                            // W
		loadBit,
		rn,
		nextReg,
		startOffset};

	assign blockNext = {cond, 3'b010, 1'b1, 1'b1, 1'b0, 1'b0, loadBit,
		uopPkg::scratchReg,              // Running address in Rz
		nextReg,
		12'(uopPkg::wordBytes)};

	assign writeback = {cond, 3'b001,
		instr[uopPkg::uBit] ? uopPkg::opcodeAdd : uopPkg::opcodeSub,
		1'b0, rn, rn,                    // Rn = Rn +/- 4N
		4'b0000, 1'b0, totalRegs, 2'b00};

	always_comb begin
		case (state)
			uopPkg::ready: begin
				case (kind)
					uopPkg::rsr:           uOpInstr = rsrMove;
					uopPkg::branchLink:    uOpInstr = linkMove;
					uopPkg::loadMultiple:  uOpInstr = blockFirst;
					uopPkg::storeMultiple: uOpInstr = blockFirst;
					default:               uOpInstr = instr;
				endcase
			end
			uopPkg::rsrSecond: uOpInstr = rsrOp;
			uopPkg::blSecond:  uOpInstr = {instr[31:25], 1'b0, instr[23:0]};   // Drop L
			uopPkg::blockXfer: begin
				if (!condPass || (remaining == 5'd0)) begin
					uOpInstr = noOp;   // Failed condition or empty list
				end else begin
					uOpInstr = blockNext;
				end
			end
			uopPkg::blockWriteback: uOpInstr = writeback;
			default: uOpInstr = instr;
		endcase
	end

endmodule

`default_nettype wire

//--- uopSequencer.sv
// Micro-op sequencer top
`timescale 1ns/1ps
`default_nettype none

module uopSequencer (
	input  logic          clk,
	input  logic          reset,
	input  uopPkg::instrT instr,
	input  uopPkg::flagsT flags,
	input  logic          stallUop,
	output logic          instrMux,
	output logic          noFlagUpdate,
	output logic          uOpStall,
	output logic          ldmStmForward,
	output logic          prevRsrState,
	output uopPkg::rzSelT regFileRz,
	output uopPkg::instrT uOpInstr
);

	uopPkg::seqKindT  kind;
	uopPkg::seqStateT state;
	logic             condPass;
	logic             inReady;
	uopPkg::regIdxT   nextReg;
	logic [4:0]       remaining;
	logic [11:0]      startOffset;
	logic             addUp;
	logic             lastReg;
	logic             noneLeft;

	condCheck cond0 (.cond(instr[uopPkg::condHi:uopPkg::condLo]), .flags, .condPass);

	uopDecoder decoder0 (.instr, .kind);

	blockTransferCounter counter0 (.clk, .reset, .stallUop, .instr, .inReady, .nextReg,
		.remaining, .startOffset, .addUp, .lastReg, .noneLeft);

	uopController ctrl0 (.clk, .reset, .stallUop, .kind, .condPass, .lastReg, .noneLeft,
		.state, .inReady, .instrMux, .noFlagUpdate, .uOpStall, .ldmStmForward,
		.prevRsrState, .regFileRz);

	uopEncoder encoder0 (.state, .kind, .instr, .condPass, .nextReg, .remaining,
		.startOffset, .addUp, .uOpInstr);

endmodule

`default_nettype wire

//--- tbUopModel.svh
// Expected micro-op words
`ifndef TB_UOP_MODEL_SVH
`define TB_UOP_MODEL_SVH

// Number of registers in an LDM/STM list
function automatic int countRegs(input logic [15:0] list);
	int n;
	n = 0;
	for (int i = 0; i < 16; i++) begin
		n += list[i];   // One per set bit
	end
	return n;
endfunction

// ADD R0, R0, #0 under the original condition
function automatic logic [31:0] noOpWord(input logic [31:0] w);
	return {w[31:28], 3'b001, 4'b0100, 1'b0, 20'h00000};
endfunction

function automatic logic [31:0] movRzWord(input logic [31:0] w);
	return {w[31:28], 3'b000, 4'b1101, 1'b0, 4'h0, 4'hf, w[11:0]};   // Rz = shifted operand
endfunction

function automatic logic [31:0] rsrSecondWord(input logic [31:0] w);
	return {w[31:12], 8'h00, 4'hf};   // Original op, Rz unshifted
endfunction

function automatic logic [31:0] linkMoveWord(input logic [31:0] w);
	return {w[31:28], 3'b000, 4'b1101, 1'b0, 4'h0, 4'he, 8'h00, 4'hf};   // MOV LR, PC
endfunction

function automatic logic [31:0] branchWord(input logic [31:0] w);
	return {w[31:25], 1'b0, w[23:0]};   // L cleared
endfunction

// First offset in bytes from P and U
function automatic logic [11:0] startOffsetOf(input logic [31:0] w, input int n);
	case ({w[24], w[23]})
		2'b00: return 12'(4 * (n - 1));   // DA
		2'b01: return 12'd0;              // IA
		2'b10: return 12'(4 * n);         // DB
		default: return 12'd4;            // IB
	endcase
endfunction

function automatic logic [31:0] blockFirstWord(input logic [31:0] w, input int r, input int n);
	return {w[31:28], 3'b010, 1'b1, w[23], 1'b0, 1'b0, w[20], w[19:16], 4'(r),
		startOffsetOf(w, n)};
endfunction

function automatic logic [31:0] blockNextWord(input logic [31:0] w, input int r);
	return {w[31:28], 3'b010, 1'b1, 1'b1, 1'b0, 1'b0, w[20], 4'hf, 4'(r), 12'd4};
endfunction

// Rn = Rn +/- 4N
function automatic logic [31:0] writebackWord(input logic [31:0] w, input int n);
	return {w[31:28], 3'b001, (w[23] ? 4'b0100 : 4'b0010), 1'b0, w[19:16], w[19:16],
		12'(4 * n)};
endfunction

`endif

//--- tbUopSequencer.sv
// Micro-op sequencer testbench
`timescale 1ns/1ps
`default_nettype none

module tbUopSequencer;

	logic          clk;
	logic          reset;
	uopPkg::instrT instr;
	uopPkg::flagsT flags;
	logic          stallUop;
	logic          instrMux;
	logic          noFlagUpdate;
	logic          uOpStall;
	logic          ldmStmForward;
	logic          prevRsrState;
	uopPkg::rzSelT regFileRz;
	uopPkg::instrT uOpInstr;

	int            errors;
	integer        seed;
	logic [31:0]   expWord[$];   // One entry per micro-op
	logic [3:0]    expRz[$];
	logic          expFwd[$];
	logic          expPrev[$];
	logic          expMux[$];
	logic          expNoFlag[$];

	uopSequencer dut (.clk, .reset, .instr, .flags, .stallUop, .instrMux, .noFlagUpdate,
		.uOpStall, .ldmStmForward, .prevRsrState, .regFileRz, .uOpInstr);

	`include "tbUopModel.svh"

	initial begin
		clk = 1'b0;
		forever #10 clk = !clk;   // 20 ns period
	end

	task automatic checkValue(input string name, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s %s: expected %h actual %h", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic pushCycle(input logic [31:0] w, input logic [3:0] rz, input logic fwd,
		input logic prev, input logic mux, input logic noFlag);
		expWord.push_back(w);
		expRz.push_back(rz);
		expFwd.push_back(fwd);
		expPrev.push_back(prev);
		expMux.push_back(mux);
		expNoFlag.push_back(noFlag);
	endtask

	// Expected LDM/STM run, condition passing or failing
	// Every cycle of the run keeps the flags
	task automatic buildBlock(input logic [31:0] w, input bit pass);
		int  n;
		bit  first;
		logic [3:0] rzLater;
		n = countRegs(w[15:0]);
		first = 1'b1;
		rzLater = w[20] ? 4'b0001 : 4'b0000;   // Loads read the base from Rz
		if (n == 0 || !pass) begin
			pushCycle(blockFirstWord(w, lowestReg(w[15:0]), n), 4'b0000, 1'b0, 1'b0, 1'b1,
				1'b1);
			pushCycle(noOpWord(w), rzLater, 1'b0, 1'b0, 1'b1, 1'b1);
		end else begin
			for (int k = 0; k < 16; k++) begin
				if (w[k] && first) begin
					pushCycle(blockFirstWord(w, k, n), 4'b0000, 1'b0, 1'b0, 1'b1, 1'b1);
					first = 1'b0;
				end else if (w[k]) begin
					pushCycle(blockNextWord(w, k), rzLater, 1'b1, 1'b0, 1'b1, 1'b1);
				end
			end
			if (w[21]) pushCycle(writebackWord(w, n), 4'b0000, 1'b0, 1'b0, 1'b1, 1'b1);
		end
	endtask

	function automatic int lowestReg(input logic [15:0] list);
		for (int i = 0; i < 16; i++) begin
			if (list[i]) return i;
		end
		return 0;   // Empty list selects R0
	endfunction

	// Drive one instruction, check every micro-op, optional hold mid-run
	task automatic runCase(input string name, input logic [31:0] w, input logic [3:0] f,
		input int holdAt, input int holdLen);
		int  idx;
		int  cycles;
		int  last;
		int  holdLeft;
		bit  finished;
		logic sawLow;
		idx = 0;
		cycles = 0;
		finished = 1'b0;
		holdLeft = holdLen;
		last = expWord.size() - 1;
		@(posedge clk);
		instr <= w;
		flags <= f;
		stallUop <= 1'b0;
		while (!finished && cycles < 40) begin
			@(negedge clk);   // Outputs settled
			checkValue(name, "uOpInstr", expWord[idx], uOpInstr);
			checkValue(name, "uOpStall", 32'(idx != last), 32'(uOpStall));
			checkValue(name, "instrMux", 32'(expMux[idx]), 32'(instrMux));
			checkValue(name, "regFileRz", 32'(expRz[idx]), 32'(regFileRz));
			checkValue(name, "ldmStmForward", 32'(expFwd[idx]), 32'(ldmStmForward));
			checkValue(name, "prevRsrState", 32'(expPrev[idx]), 32'(prevRsrState));
			checkValue(name, "noFlagUpdate", 32'(expNoFlag[idx]), 32'(noFlagUpdate));
			sawLow = !uOpStall;
			cycles++;
			@(posedge clk);
			if (!stallUop) begin   // Held edges repeat the same micro-op
				if (sawLow) begin
					finished = 1'b1;
				end else if (idx < last) begin
					idx++;
				end
			end
			if (!finished && idx == holdAt && holdLeft > 0) begin
				stallUop <= 1'b1;
				holdLeft--;
			end else begin
				stallUop <= 1'b0;
			end
		end
		if (!finished) begin
			$display("Timeout in %s: uOpStall never went low", name);
			errors++;
		end
		instr <= 32'he1a00000;   // MOV r0, r0 keeps the sequencer idle
		stallUop <= 1'b0;
		expWord.delete();
		expRz.delete();
		expFwd.delete();
		expPrev.delete();
		expMux.delete();
		expNoFlag.delete();
	endtask

	initial begin
		logic [31:0] w;
		logic [15:0] list;
		errors = 0;
		seed = 32'hc03f;
		reset = 1'b1;
		instr = 32'he1a00000;
		flags = 4'h0;
		stallUop = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		w = 32'he0812003;   // ADD r2, r1, r3
		pushCycle(w, 4'b0000, 1'b0, 1'b0, 1'b0, 1'b0);
		runCase("plain", w, 4'h0, -1, 0);

		w = 32'he0812413;   // ADD r2, r1, r3, LSL r4
		pushCycle(movRzWord(w), 4'b1100, 1'b0, 1'b0, 1'b1, 1'b1);
		pushCycle(rsrSecondWord(w), 4'b0010, 1'b0, 1'b1, 1'b1, 1'b0);
		runCase("rsr", w, 4'h0, -1, 0);

		w = 32'heb000010;   // BL
		pushCycle(linkMoveWord(w), 4'b0000, 1'b0, 1'b0, 1'b1, 1'b0);
		pushCycle(branchWord(w), 4'b0000, 1'b0, 1'b0, 1'b1, 1'b0);
		runCase("bl", w, 4'h0, -1, 0);

		for (int wb = 0; wb < 2; wb++) begin
			for (int mode = 0; mode < 4; mode++) begin
				list = 16'($random(seed));
				if (list == 16'h0000) list = 16'h0080;
				w = {4'he, 3'b100, 2'(mode), 1'b0, 1'(wb), 1'($random(seed)),
					4'($random(seed)), list};
				buildBlock(w, 1'b1);
				runCase(wb ? "blockWriteback" : "blockPlain", w, 4'($random(seed)), -1, 0);
			end
		end

		w = {4'he, 3'b100, 2'b01, 1'b0, 1'b1, 1'b1, 4'($random(seed)), 16'h0000};   // Empty IA
		buildBlock(w, 1'b1);
		runCase("blockEmpty", w, 4'h0, -1, 0);

		list = 16'($random(seed)) | 16'h0003;
		w = {4'h0, 3'b100, 2'b01, 1'b0, 1'b0, 1'b1, 4'($random(seed)), list};   // LDMEQ
		buildBlock(w, 1'b0);
		runCase("condFail", w, 4'($random(seed)) & 4'b1011, -1, 0);   // Z clear

		list = 16'($random(seed)) | 16'h0111;
		w = {4'he, 3'b100, 2'b11, 1'b0, 1'b1, 1'b1, 4'($random(seed)), list};
		buildBlock(w, 1'b1);
		runCase("holdMidRun", w, 4'h0, 1, 1 + ($random(seed) & 3));

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- uopSequencer.f
+incdir+.
uopPkg.sv
condCheck.sv
uopDecoder.sv
blockTransferCounter.sv
uopController.sv
uopEncoder.sv
uopSequencer.sv
tbUopSequencer.sv

//--- run.sh
#!/bin/sh
# Build and run the sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbUopSequencer \
	-f uopSequencer.f -o simv
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
	exit 0
fi
exit 1
